// ==== hdl/pwm_sys_pkg.sv ====
// Single-master AHB-Lite types and codes; word accesses only, no bursts, split or retry
package pwm_sys_pkg;

    // Transfer type codes, HTRANS
    localparam logic [1:0] htrans_idle   = 2'b00;   // No transfer
    localparam logic [1:0] htrans_busy   = 2'b01;   // Master busy inside a burst
    localparam logic [1:0] htrans_nonseq = 2'b10;   // Single or first transfer
    localparam logic [1:0] htrans_seq    = 2'b11;   // Following burst beat

    // Response codes, HRESP
    localparam logic hresp_okay  = 1'b0;            // Transfer done
    localparam logic hresp_error = 1'b1;            // Unmapped or failed transfer

    // PWM register byte offsets, bits [3:2] select the word
    localparam logic [3:0] reg_compare_off = 4'h0;  // Output high while count below
    localparam logic [3:0] reg_period_off  = 4'h4;  // Count wraps at period - 1
    localparam logic [3:0] reg_enable_off  = 4'h8;  // Bit 0 runs the counter

    // Slave window select
    // Each slave owns 4 KB, index lives in haddr[15:12]
    localparam int slave_addr_lsb = 12;

    // Master to slave request, one set per address phase
    typedef struct packed {
        logic [31:0] haddr;     // Byte address
        logic [31:0] hwdata;    // Write data, valid in data phase
        logic        hwrite;    // 1 = write
        logic [1:0]  htrans;    // Transfer type
        logic [2:0]  hsize;     // Carried, not decoded
        logic [2:0]  hburst;    // Carried, not decoded
        logic        hsel;      // Slave select
    } ahb_req_t;

    // Slave to master response
    typedef struct packed {
        logic [31:0] hrdata;    // Read data, valid in data phase
        logic        hready;    // Low stretches the data phase
        logic        hresp;     // OKAY or ERROR
    } ahb_resp_t;

endpackage : pwm_sys_pkg

// ==== hdl/ahb_slave_decoder.sv ====
// Up to 16 slaves in 4 KB windows from address 0; haddr[31:16] must be 0 or the transfer errors
`timescale 1ns/1ps

module ahb_slave_decoder #(
    parameter int num_channels = 2
) (
    input  logic                   hclk,
    input  logic                   reset,
    input  pwm_sys_pkg::ahb_req_t  req,                         // From master
    output pwm_sys_pkg::ahb_resp_t resp,                        // To master
    output pwm_sys_pkg::ahb_req_t  slave_req  [num_channels],   // To each slave
    input  pwm_sys_pkg::ahb_resp_t slave_resp [num_channels]    // From each slave
);

    localparam int idx_w = 4;                   // haddr[15:12]

    typedef enum logic [1:0] {
        st_okay,                                // Normal routing
        st_err_wait,                            // First ERROR cycle, hready low
        st_err_last                             // Second ERROR cycle, hready high
    } err_state_t;

    err_state_t              state;
    logic [idx_w-1:0]        addr_idx;          // Slave index of address phase
    logic [num_channels-1:0] hit;               // One-hot slave match
    logic                    upper_zero;        // haddr[31:16] clear
    logic                    active;            // NONSEQ or SEQ with hsel
    logic                    mapped;            // Some slave covers the address
    logic                    hready_out;
    logic [idx_w-1:0]        sel_q;             // Data phase slave index
    logic                    sel_valid_q;       // Data phase belongs to a slave
    pwm_sys_pkg::ahb_resp_t  slave_mux;

    assign addr_idx   = req.haddr[pwm_sys_pkg::slave_addr_lsb +: idx_w];
    assign upper_zero = (req.haddr[31:16] == 16'h0000);
    assign active     = req.hsel && (req.htrans == pwm_sys_pkg::htrans_nonseq ||
                                     req.htrans == pwm_sys_pkg::htrans_seq);
    assign mapped     = |hit;
    assign hready_out = resp.hready;

    always_comb begin
        for (int i = 0; i < num_channels; i++) begin
            hit[i]            = upper_zero && (addr_idx == idx_w'(i));
            slave_req[i]      = req;
            // Slaves only see the address phase once the bus is free
            slave_req[i].hsel = req.hsel && hit[i] && hready_out;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            sel_q       <= '0;
            sel_valid_q <= 1'b0;
        end else if (hready_out) begin                  // New address phase accepted
            sel_q       <= addr_idx;
            sel_valid_q <= active && mapped;
        end
    end

    always_ff @(posedge hclk) begin
        if (reset) begin
            state <= st_okay;
        end else begin
            case (state)
                st_err_wait: state <= st_err_last;      // Always two cycles
                default:     state <= (active && !mapped) ? st_err_wait : st_okay;
            endcase
        end
    end

    always_comb begin
        slave_mux = '{hrdata: 32'h0, hready: 1'b1, hresp: pwm_sys_pkg::hresp_okay};
        for (int i = 0; i < num_channels; i++) begin
            if (sel_valid_q && (sel_q == idx_w'(i))) slave_mux = slave_resp[i];
        end
    end

    always_comb begin
        case (state)
            st_err_wait: resp = '{hrdata: 32'h0, hready: 1'b0, hresp: pwm_sys_pkg::hresp_error};
            st_err_last: resp = '{hrdata: 32'h0, hready: 1'b1, hresp: pwm_sys_pkg::hresp_error};
            default:     resp = slave_mux;              // Idle or mapped data phase
        endcase
    end

endmodule : ahb_slave_decoder

// ==== hdl/pwm_core.sv ====
// Settings reach pwm_clk after a variable toggle-handshake delay and apply at a period boundary
`timescale 1ns/1ps

module pwm_core #(
    parameter int pwm_width = 8
) (
    input  logic        hclk,
    input  logic        reset,
    // Register port
    input  logic [1:0]  reg_sel,    // Word address
    input  logic        we,         // Write enable
    input  logic [31:0] wd,         // Write data
    output logic [31:0] rd,         // Read data, zero-extended
    // PWM side
    input  logic        pwm_clk,
    input  logic        pwm_reset,
    output logic        pwm
);

    typedef struct packed {
        logic [pwm_width-1:0] compare;  // High while count below
        logic [pwm_width-1:0] period;   // Cycles per PWM period
        logic                 enable;   // Counter runs
    } pwm_cfg_t;

    localparam logic [pwm_width-1:0] cnt_one = pwm_width'(1);

    // hclk side
    pwm_cfg_t             cfg;          // Bus-visible registers
    pwm_cfg_t             snap;         // Stable while a crossing is in flight
    logic                 pending;      // Write not yet sent across
    logic                 launch;       // Start a crossing
    logic                 req_tgl;      // Request toggle
    logic                 ack_meta;
    logic                 ack_sync;     // Ack toggle in hclk

    // pwm_clk side
    pwm_cfg_t             shadow;       // Settings in use
    logic                 req_meta;
    logic                 req_sync;     // Request toggle in pwm_clk
    logic                 ack_tgl;      // Ack toggle
    logic                 new_cfg;      // Snapshot waiting to load
    logic                 boundary;     // Last cycle of a period
    logic [pwm_width-1:0] cnt;

    // Register writes
    always_ff @(posedge hclk) begin
        if (reset) begin
            cfg     <= '0;
            pending <= 1'b0;
        end else begin
            if (we) begin
                case (reg_sel)
                    pwm_sys_pkg::reg_compare_off[3:2]: cfg.compare <= wd[pwm_width-1:0];
                    pwm_sys_pkg::reg_period_off[3:2]:  cfg.period  <= wd[pwm_width-1:0];
                    pwm_sys_pkg::reg_enable_off[3:2]:  cfg.enable  <= wd[0];
                    default: ;                              // Unused word
                endcase
            end
            pending <= we || (pending && !launch);          // Late writes resend
        end
    end

    always_comb begin
        case (reg_sel)
            pwm_sys_pkg::reg_compare_off[3:2]: rd = 32'(cfg.compare);
            pwm_sys_pkg::reg_period_off[3:2]:  rd = 32'(cfg.period);
            pwm_sys_pkg::reg_enable_off[3:2]:  rd = 32'(cfg.enable);
            default:                           rd = 32'h0;
        endcase
    end

    // Request side of the handshake
    assign launch = pending && (req_tgl == ack_sync);       // Nothing in flight

    always_ff @(posedge hclk) begin
        if (reset) begin
            req_tgl  <= 1'b0;
            ack_meta <= 1'b0;
            ack_sync <= 1'b0;
        end else begin
            ack_meta <= ack_tgl;
            ack_sync <= ack_meta;
            if (launch) req_tgl <= !req_tgl;
        end
    end

    always_ff @(posedge hclk) begin
        if (launch) snap <= cfg;
    end

    // pwm_clk side load and ack
    assign new_cfg  = (req_sync != ack_tgl);
    assign boundary = !shadow.enable || (shadow.period == '0) ||
                      (cnt >= shadow.period - cnt_one);

    always_ff @(posedge pwm_clk) begin
        if (pwm_reset) begin
            req_meta <= 1'b0;
            req_sync <= 1'b0;
            ack_tgl  <= 1'b0;
            shadow   <= '0;
        end else begin
            req_meta <= req_tgl;
            req_sync <= req_meta;
            if (new_cfg && boundary) begin      // Glitch-free switch
                shadow  <= snap;
                ack_tgl <= req_sync;
            end
        end
    end

    // Counter and compare
    always_ff @(posedge pwm_clk) begin
        if (pwm_reset) begin
            cnt <= '0;
            pwm <= 1'b0;
        end else begin
            cnt <= boundary ? '0 : cnt + cnt_one;   // Wrap, or hold when idle
            pwm <= shadow.enable && (shadow.period != '0) && (cnt < shadow.compare);
        end
    end

endmodule : pwm_core

// ==== hdl/ahb_pwm.sv ====
// AHB-Lite PWM slave with zero wait states; 32-bit word accesses only, hsize and hburst ignored
`timescale 1ns/1ps

module ahb_pwm #(
    parameter int pwm_width = 8
) (
    input  logic                   hclk,
    input  logic                   reset,
    // Bus side
    input  pwm_sys_pkg::ahb_req_t  req,         // Request with decoded hsel
    output pwm_sys_pkg::ahb_resp_t resp,        // Always ready, always OKAY
    // PWM side
    input  logic                   pwm_clk,     // PWM counter clock
    input  logic                   pwm_reset,   // Sync to pwm_clk
    output logic                   pwm          // PWM output
);

    logic        request;                       // Active address phase
    logic [1:0]  addr_q;                        // Word address for data phase
    logic        wreq_q;                        // Data phase is a write
    logic        act_q;                         // Data phase is ours
    logic [31:0] core_rd;                       // Register read data

    assign request = req.hsel && (req.htrans == pwm_sys_pkg::htrans_nonseq ||
                                  req.htrans == pwm_sys_pkg::htrans_seq);

    // Address phase capture
    always_ff @(posedge hclk) begin
        if (reset) begin
            addr_q <= 2'b00;
            wreq_q <= 1'b0;
            act_q  <= 1'b0;
        end else begin
            wreq_q <= request && req.hwrite;    // One cycle write strobe
            act_q  <= request;
            if (request) begin
                addr_q <= req.haddr[3:2];       // Hold last word address
            end
        end
    end

    // Data phase response
    assign resp.hrdata = act_q ? core_rd : 32'h0;   // Quiet outside own data phase
    assign resp.hready = 1'b1;                      // No wait states
    assign resp.hresp  = pwm_sys_pkg::hresp_okay;

    pwm_core #(
        .pwm_width  ( pwm_width  )
    ) pwm_core_0 (
        .hclk       ( hclk       ),
        .reset      ( reset      ),
        // Register port
        .reg_sel    ( addr_q     ),     // Word address
        .we         ( wreq_q     ),     // Write enable
        .wd         ( req.hwdata ),     // Write data from data phase
        .rd         ( core_rd    ),     // Read data
        // PWM side
        .pwm_clk    ( pwm_clk    ),
        .pwm_reset  ( pwm_reset  ),
        .pwm        ( pwm        )
    );

endmodule : ahb_pwm

// ==== hdl/pwm_subsystem_top.sv ====
// One AHB-Lite master, num_channels PWM slaves at 4 KB steps from 0; pwm_clk is asynchronous
`timescale 1ns/1ps

module pwm_subsystem_top #(
    parameter int pwm_width    = 8,     // Counter, compare and period width
    parameter int num_channels = 2      // PWM slaves, 1 to 16
) (
    input  logic                    hclk,
    input  logic                    reset,
    // Bus side
    input  pwm_sys_pkg::ahb_req_t   ahb_req,
    output pwm_sys_pkg::ahb_resp_t  ahb_resp,
    // PWM side
    input  logic                    pwm_clk,
    input  logic                    pwm_reset,
    output logic [num_channels-1:0] pwm
);

    pwm_sys_pkg::ahb_req_t  slave_req  [num_channels];  // Per slave, own hsel
    pwm_sys_pkg::ahb_resp_t slave_resp [num_channels];

    ahb_slave_decoder #(
        .num_channels ( num_channels )
    ) decoder_0 (
        .hclk         ( hclk         ),
        .reset        ( reset        ),
        .req          ( ahb_req      ),
        .resp         ( ahb_resp     ),
        .slave_req    ( slave_req    ),
        .slave_resp   ( slave_resp   )
    );

    for (genvar i = 0; i < num_channels; i++) begin : gen_channel
        ahb_pwm #(
            .pwm_width ( pwm_width     )
        ) ahb_pwm_i (
            .hclk      ( hclk          ),
            .reset     ( reset         ),
            .req       ( slave_req[i]  ),
            .resp      ( slave_resp[i] ),
            .pwm_clk   ( pwm_clk       ),
            .pwm_reset ( pwm_reset     ),
            .pwm       ( pwm[i]        )
        );
    end

endmodule : pwm_subsystem_top

// ==== verification/tb_pwm_subsystem.sv ====
// Directed tests for two 8-bit channels; settle waits assume periods up to 255 pwm_clk cycles
`timescale 1ns/1ps

module tb_pwm_subsystem;

    localparam int pwm_width      = 8;
    localparam int num_channels   = 2;
    localparam int hready_timeout = 20;                         // hclk cycles per wait
    localparam int max_period     = (1 << pwm_width) - 1;
    localparam int settle_cycles  = 5 * max_period + 20;        // pwm_clk cycles after last write
    localparam logic [31:0] data_mask = 32'((1 << pwm_width) - 1);

    logic                    hclk;
    logic                    reset;
    logic                    pwm_clk;
    logic                    pwm_reset;
    pwm_sys_pkg::ahb_req_t   ahb_req;
    pwm_sys_pkg::ahb_resp_t  ahb_resp;
    logic [num_channels-1:0] pwm;

    int          errors;
    int          checks;
    int          wait_cycles;                                   // hready low in last data phase
    logic        timed_out;                                     // A wait gave up
    logic [31:0] model [num_channels][3];                       // Expected compare, period, enable

    pwm_subsystem_top #(
        .pwm_width    ( pwm_width    ),
        .num_channels ( num_channels )
    ) uut (
        .hclk         ( hclk         ),
        .reset        ( reset        ),
        .ahb_req      ( ahb_req      ),
        .ahb_resp     ( ahb_resp     ),
        .pwm_clk      ( pwm_clk      ),
        .pwm_reset    ( pwm_reset    ),
        .pwm          ( pwm          )
    );

    initial begin
        hclk = 1'b0;
        forever #50 hclk = ~hclk;                               // 100 ns
    end

    initial begin
        pwm_clk = 1'b0;
        forever #65 pwm_clk = ~pwm_clk;                         // 130 ns, unrelated to hclk
    end

    initial begin
        pwm_reset = 1'b1;
        repeat (3) @(posedge pwm_clk);
        pwm_reset <= 1'b0;
    end

    task automatic finish_run();
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    endtask

    task automatic check_rdata(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected 0x%08h, actual 0x%08h", name, expected, actual);
        end
    endtask

    task automatic check_resp(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("[FAIL] %s: expected hresp %0b, actual hresp %0b", name, expected, actual);
        end
    endtask

    task automatic check_wait_cycles(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %s: expected %0d wait cycles, actual %0d", name, expected, actual);
        end
    endtask

    task automatic check_high_count(input string name, input int expected, input int actual);
        checks++;
        if (actual != expected) begin
            errors++;
            $display("[FAIL] %s: expected %0d high cycles, actual %0d", name, expected, actual);
        end
    endtask

    function automatic logic [3:0] reg_off(input int idx);
        case (idx)
            0:       return pwm_sys_pkg::reg_compare_off;
            1:       return pwm_sys_pkg::reg_period_off;
            default: return pwm_sys_pkg::reg_enable_off;
        endcase
    endfunction

    function automatic logic [31:0] reg_addr(input int ch, input int idx);
        return (32'(ch) << pwm_sys_pkg::slave_addr_lsb) | {28'h0, reg_off(idx)};
    endfunction

    // Off or zero period never goes high and compare at or above period always does
    function automatic int expected_high(input logic [31:0] c, input logic [31:0] p,
                                         input logic [31:0] en, input int window);
        if (en[0] == 1'b0 || p == 32'h0) return 0;
        if (c >= p) return window;
        return int'(c);
    endfunction

    task automatic wait_hready(input string phase, output int waits);
        waits = 0;
        @(negedge hclk);                                        // Sample away from the edge
        while (ahb_resp.hready !== 1'b1 && waits < hready_timeout) begin
            @(negedge hclk);
            waits++;
        end
        if (ahb_resp.hready !== 1'b1) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: hready stayed low for %0d cycles in the %s",
                     hready_timeout, phase);
        end
    endtask

    task automatic ahb_transfer(input logic [31:0] addr, input logic is_write,
                                input logic [31:0] data, output pwm_sys_pkg::ahb_resp_t resp);
        int waits;
        @(posedge hclk);
        ahb_req.haddr  <= addr;
        ahb_req.hwrite <= is_write;
        ahb_req.htrans <= pwm_sys_pkg::htrans_nonseq;
        ahb_req.hsize  <= 3'b010;                               // Word
        ahb_req.hsel   <= 1'b1;
        wait_hready("address phase", waits);
        @(posedge hclk);                                        // Address taken here
        ahb_req.hwdata <= is_write ? data : 32'h0;
        ahb_req.htrans <= pwm_sys_pkg::htrans_idle;
        ahb_req.hsel   <= 1'b0;
        wait_hready("data phase", wait_cycles);                 // Stretched on ERROR
        resp = ahb_resp;
    endtask

    task automatic ahb_write(input logic [31:0] addr, input logic [31:0] data,
                             output pwm_sys_pkg::ahb_resp_t resp);
        ahb_transfer(addr, 1'b1, data, resp);
    endtask

    task automatic ahb_read(input logic [31:0] addr, output pwm_sys_pkg::ahb_resp_t resp);
        ahb_transfer(addr, 1'b0, 32'h0, resp);
    endtask

    task automatic write_reg(input int ch, input int idx, input logic [31:0] data);
        pwm_sys_pkg::ahb_resp_t r;
        string                  name;
        name = $sformatf("write ch%0d reg%0d", ch, idx);
        ahb_write(reg_addr(ch, idx), data, r);
        check_resp(name, pwm_sys_pkg::hresp_okay, r.hresp);
        check_wait_cycles(name, 0, wait_cycles);
        model[ch][idx] = (idx == 2) ? (data & 32'h1) : (data & data_mask);  // Enable is 1 bit
    endtask

    task automatic verify_regs(input int ch, input string name);
        pwm_sys_pkg::ahb_resp_t r;
        for (int idx = 0; idx < 3; idx++) begin
            ahb_read(reg_addr(ch, idx), r);
            check_rdata($sformatf("%s ch%0d reg%0d", name, ch, idx), model[ch][idx], r.hrdata);
            check_resp($sformatf("%s ch%0d reg%0d", name, ch, idx), pwm_sys_pkg::hresp_okay,
                       r.hresp);
            check_wait_cycles($sformatf("%s ch%0d reg%0d", name, ch, idx), 0, wait_cycles);
        end
    endtask

    task automatic program_channel(input int ch, input logic [31:0] c, input logic [31:0] p,
                                   input logic [31:0] en);
        write_reg(ch, 0, c);
        write_reg(ch, 1, p);
        write_reg(ch, 2, en);
    endtask

    // One period from a rising edge, or any window while the output is flat
    task automatic measure_pwm(input int ch, input int window, output int high);
        logic prev;
        logic found;
        int   t;
        for (t = 0; t < settle_cycles; t++) @(posedge pwm_clk);   // Let the crossing finish
        found = 1'b0;
        @(negedge pwm_clk);
        prev = pwm[ch];
        t    = 0;
        while (!found && t < 2 * window + 8) begin
            @(negedge pwm_clk);
            found = !prev && pwm[ch];
            prev  = pwm[ch];
            t++;
        end
        high = 0;
        for (int i = 0; i < window; i++) begin
            if (i > 0 || !found) @(negedge pwm_clk);            // Rising sample is cycle 0
            if (pwm[ch]) high++;
        end
    endtask

    task automatic check_channel(input int ch, input string name);
        int window;
        int high;
        window = (model[ch][1] == 32'h0) ? 16 : int'(model[ch][1]);
        measure_pwm(ch, window, high);
        check_high_count($sformatf("%s ch%0d", name, ch),
                         expected_high(model[ch][0], model[ch][1], model[ch][2], window), high);
    endtask

    task automatic test_reset();
        for (int ch = 0; ch < num_channels; ch++) begin
            verify_regs(ch, "reset value");
            check_channel(ch, "reset output");
        end
    endtask

    task automatic test_regs();
        for (int n = 0; n < 4; n++) begin
            for (int ch = 0; ch < num_channels; ch++) begin
                for (int idx = 0; idx < 3; idx++) write_reg(ch, idx, $urandom());
                verify_regs(ch, $sformatf("readback round %0d", n));
                verify_regs(num_channels - 1 - ch, "untouched channel");
            end
        end
    endtask

    task automatic test_duty();
        int p0 [3] = '{10, 7, 255};
        int c0 [3] = '{3, 1, 128};
        int p1 [3] = '{20, 50, 2};
        int c1 [3] = '{15, 25, 1};
        for (int k = 0; k < 3; k++) begin
            program_channel(0, 32'(c0[k]), 32'(p0[k]), 32'h1);
            program_channel(1, 32'(c1[k]), 32'(p1[k]), 32'h1);
            check_channel(0, $sformatf("duty pair %0d", k));
            check_channel(1, $sformatf("duty pair %0d", k));
        end
    endtask

    task automatic test_edges();
        program_channel(0, 32'd12, 32'd10, 32'h1);                // Compare above period
        program_channel(1, 32'd9, 32'd9, 32'h1);                  // Compare equal to period
        check_channel(0, "compare over period");
        check_channel(1, "compare equal period");
        program_channel(0, 32'd0, 32'd10, 32'h1);
        program_channel(1, 32'd5, 32'd9, 32'h0);
        check_channel(0, "compare zero");
        check_channel(1, "enable clear");
        program_channel(0, 32'd5, 32'd0, 32'h1);
        check_channel(0, "period zero");
    endtask

    task automatic test_back_to_back();
        program_channel(0, 32'd2, 32'd20, 32'h1);
        for (int k = 0; k < 5; k++) write_reg(0, 0, 32'(3 + 3 * k));    // Ends at 15
        verify_regs(0, "back to back");
        check_channel(0, "last compare wins");
    endtask

    task automatic test_unmapped();
        pwm_sys_pkg::ahb_resp_t r;
        ahb_read(32'h0000_2000, r);                             // Slave index 2
        check_resp("read index 2", pwm_sys_pkg::hresp_error, r.hresp);
        check_rdata("read index 2", 32'h0, r.hrdata);
        check_wait_cycles("read index 2", 1, wait_cycles);
        ahb_write(32'h0000_3004, 32'h55, r);
        check_resp("write index 3", pwm_sys_pkg::hresp_error, r.hresp);
        check_wait_cycles("write index 3", 1, wait_cycles);
        ahb_read(32'h0001_0000, r);                             // Upper bits set
        check_resp("read upper bits", pwm_sys_pkg::hresp_error, r.hresp);
        check_rdata("read upper bits", 32'h0, r.hrdata);
        check_wait_cycles("read upper bits", 1, wait_cycles);
        ahb_write(32'h8000_0008, 32'h1, r);
        check_resp("write upper bits", pwm_sys_pkg::hresp_error, r.hresp);
        check_wait_cycles("write upper bits", 1, wait_cycles);
        verify_regs(0, "after error");                          // OKAY again, nothing changed
        verify_regs(1, "after error");
    endtask

    initial begin
        void'($urandom(32'h72dd));
        errors      = 0;
        checks      = 0;
        wait_cycles = 0;
        timed_out   = 1'b0;
        reset       = 1'b1;
        ahb_req     = '0;
        for (int ch = 0; ch < num_channels; ch++) begin
            for (int idx = 0; idx < 3; idx++) model[ch][idx] = 32'h0;
        end
        repeat (3) @(posedge hclk);
        reset <= 1'b0;
        for (int t = 0; pwm_reset !== 1'b0 && t <= hready_timeout; t++) @(negedge hclk);
        if (pwm_reset !== 1'b0) begin
            errors++;
            timed_out = 1'b1;
            $display("Timeout: pwm_reset was never released");
        end
        if (!timed_out) test_reset();
        if (!timed_out) test_regs();
        if (!timed_out) test_duty();
        if (!timed_out) test_edges();
        if (!timed_out) test_back_to_back();
        if (!timed_out) test_unmapped();
        finish_run();
    end

endmodule : tb_pwm_subsystem

// ==== compile.f ====
hdl/pwm_sys_pkg.sv
hdl/ahb_slave_decoder.sv
hdl/pwm_core.sv
hdl/ahb_pwm.sv
hdl/pwm_subsystem_top.sv
verification/tb_pwm_subsystem.sv

// ==== Makefile ====
# Verilator build and run for the PWM subsystem testbench

VERILATOR  ?= verilator
TOP        := tb_pwm_subsystem
RTL_TOP    := pwm_subsystem_top
FILELIST   := compile.f
BUILD_DIR  := obj_dir
LOG        := sim.log
PASS_MSG   := ALL CHECKS PASSED
FLAGS      := --binary --timing -j 0 -Mdir $(BUILD_DIR)
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) \
		hdl/pwm_sys_pkg.sv hdl/ahb_slave_decoder.sv hdl/pwm_core.sv \
		hdl/ahb_pwm.sv hdl/pwm_subsystem_top.sv

clean:
	rm -rf $(BUILD_DIR) $(LOG)
